// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_tag_boot
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+.
tag_pkg.sv
trace_rd_if.sv
tag_trace_mem.sv
tag_trace_replay.sv
tag_client.sv
tag_boot_top.sv
tag_boot_props.sv
tb_tag_boot.sv

// File: tag_boot_props.sv
`timescale 1ns/1ps
`default_nettype none

module tag_boot_props
  (input logic clk_i
  ,input logic rst_i
  ,input logic wb_cyc_i
  ,input logic wb_stb_i
  ,input logic wb_ack_i
  ,input logic busy_i
  ,input logic done_i
  ,input logic tag_data_i
  );

  // Ack only inside an open bus cycle
  ack_in_cycle_a: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o high without cyc and stb");

  ack_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o high for two cycles in a row");

  busy_done_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(busy_i && done_i))
    else $error("busy_o and done_o high together");

  // Serial line idles low outside a replay
  line_idle_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !busy_i |-> !tag_data_i)
    else $error("tag_data_o high while not busy");

  reset_state_a: assert property (@(posedge clk_i)
    rst_i |=> (!busy_i && !done_i))
    else $error("busy_o or done_o high after reset");

endmodule

bind tag_boot_top tag_boot_props i_tag_boot_props
  (.clk_i      (clk_i)
  ,.rst_i      (rst_i)
  ,.wb_cyc_i   (wb_cyc_i)
  ,.wb_stb_i   (wb_stb_i)
  ,.wb_ack_i   (wb_ack_o)
  ,.busy_i     (busy_o)
  ,.done_i     (done_o)
  ,.tag_data_i (tag_data_o)
  );

`default_nettype wire

// File: tag_boot_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_boot_top
  (input  logic                     clk_i
  ,input  logic                     rst_i
  ,input  logic                     start_i

  ,input  logic                     wb_cyc_i
  ,input  logic                     wb_stb_i
  ,input  logic                     wb_we_i
  ,input  logic [`TAG_TRACE_AW-1:0] wb_adr_i
  ,input  logic [31:0]              wb_dat_i
  ,output logic [31:0]              wb_dat_o
  ,output logic                     wb_ack_o

  ,output logic                     busy_o
  ,output logic                     done_o
  ,output logic                     tag_data_o
  ,output tag_pkg::tag_payload_t    cfg0_o
  ,output tag_pkg::tag_payload_t    cfg1_o
  );

  trace_rd_if trace_rd ();

  ////////////////////
  // Trace storage

  tag_trace_mem i_tag_trace_mem
    (.clk_i    (clk_i)
    ,.rst_i    (rst_i)
    ,.wb_cyc_i (wb_cyc_i)
    ,.wb_stb_i (wb_stb_i)
    ,.wb_we_i  (wb_we_i)
    ,.wb_adr_i (wb_adr_i)
    ,.wb_dat_i (wb_dat_i)
    ,.wb_dat_o (wb_dat_o)
    ,.wb_ack_o (wb_ack_o)
    ,.rd       (trace_rd.mem)
    );

  ////////////////////
  // Replay engine

  tag_trace_replay i_tag_trace_replay
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.start_i    (start_i)
    ,.rd         (trace_rd.replay)
    ,.tag_data_o (tag_data_o)
    ,.busy_o     (busy_o)
    ,.done_o     (done_o)
    );

  // Both clients share the one serial line
  tag_client #(.node_id_p(`TAG_NODE_W'(0))) i_tag_client_0
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.tag_data_i (tag_data_o)
    ,.cfg_o      (cfg0_o)
    );

  tag_client #(.node_id_p(`TAG_NODE_W'(1))) i_tag_client_1
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.tag_data_i (tag_data_o)
    ,.cfg_o      (cfg1_o)
    );

endmodule

`default_nettype wire

// File: tag_client.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_client
  #(parameter logic [`TAG_NODE_W-1:0] node_id_p = '0)
  (input  logic                  clk_i
  ,input  logic                  rst_i
  ,input  logic                  tag_data_i
  ,output tag_pkg::tag_payload_t cfg_o
  );

  import tag_pkg::*;

  localparam int hdr_w_lp = `TAG_NODE_W + `TAG_LEN_W;
  localparam logic [`TAG_LEN_W-1:0] hdr_last_lp = (`TAG_LEN_W)'(hdr_w_lp - 1);

  client_state_e         state_r;
  logic [`TAG_LEN_W-1:0] cnt_r;
  logic [hdr_w_lp-1:0]   hdr_r;
  logic [hdr_w_lp-1:0]   hdr_nxt;
  tag_payload_t          data_r;
  tag_payload_t          data_nxt;
  logic [`TAG_LEN_W-1:0] len_w;
  logic                  match_w;

  // Header arrives LSB first, node then len
  assign hdr_nxt = {tag_data_i, hdr_r[hdr_w_lp-1:1]};
  assign len_w   = hdr_r[hdr_w_lp-1:`TAG_NODE_W];
  assign match_w = (hdr_r[`TAG_NODE_W-1:0] == node_id_p);

  always_comb
  begin
    data_nxt        = data_r;
    data_nxt[cnt_r] = tag_data_i;
  end

  ////////////////////
  // Deserializer FSM

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= CLIENT_IDLE;
      cnt_r   <= '0;
      cfg_o   <= '0;
    end
    else
    begin
      case (state_r)
        CLIENT_IDLE:
          if (tag_data_i)
          begin
            state_r <= CLIENT_HEADER;
            cnt_r   <= '0;
          end
        CLIENT_HEADER:
          if (cnt_r == hdr_last_lp)
          begin
            state_r <= CLIENT_PAYLOAD;
            cnt_r   <= '0;
          end
          else
            cnt_r <= cnt_r + 1'b1;
        CLIENT_PAYLOAD:
          // Runs to the end even for other nodes
          if (cnt_r == len_w)
          begin
            state_r <= CLIENT_IDLE;
            if (match_w)
              cfg_o <= data_nxt;
          end
          else
            cnt_r <= cnt_r + 1'b1;
        default:
          state_r <= CLIENT_IDLE;
      endcase
    end
  end

  ////////////////////
  // Shift registers

  always_ff @(posedge clk_i)
  begin
    if (state_r == CLIENT_HEADER)
      hdr_r <= hdr_nxt;

    // Upper bits stay zero for short payloads
    if ((state_r == CLIENT_HEADER) && (cnt_r == hdr_last_lp))
      data_r <= '0;
    else if (state_r == CLIENT_PAYLOAD)
      data_r <= data_nxt;
  end

endmodule

`default_nettype wire

// File: tag_pkg.sv
`default_nettype none

`include "tag_settings.svh"

package tag_pkg;

  // Trace opcodes, code 2'b11 acts as done
  typedef enum logic [1:0] {
    TAG_OP_SEND = 2'b00,
    TAG_OP_WAIT = 2'b01,
    TAG_OP_DONE = 2'b10
  } tag_op_e;

  typedef logic [`TAG_PAYLOAD_W-1:0] tag_payload_t;

  // One 32-bit trace entry
  typedef struct packed {
    tag_op_e                 op;
    logic [`TAG_NODE_W-1:0]  node;
    logic [`TAG_LEN_W-1:0]   len;
    logic [7:0]              rsvd;
    tag_payload_t            payload;
  } tag_entry_t;

  typedef enum logic [2:0] {
    REPLAY_IDLE,
    REPLAY_FETCH,
    REPLAY_DECODE,
    REPLAY_SHIFT,
    REPLAY_WAIT,
    REPLAY_DONE
  } replay_state_e;

  typedef enum logic [1:0] {
    CLIENT_IDLE,
    CLIENT_HEADER,
    CLIENT_PAYLOAD
  } client_state_e;

endpackage

`default_nettype wire

// File: tag_settings.svh
`ifndef TAG_SETTINGS_SVH
`define TAG_SETTINGS_SVH

// Trace memory address width, 32 entries
`define TAG_TRACE_AW 5

// Tag packet header fields
`define TAG_NODE_W 2
`define TAG_LEN_W 4

// Configuration payload and wait count
`define TAG_PAYLOAD_W 16

`endif

// File: tag_stim.txt
# Columns: W addr entry | R addr entry | S min_cycles | C cfg0 cfg1 | X run_cycles
# All values hex; X 0 resets without starting a replay first
W 00 0FAAA5C3
W 01 1F001234
W 02 2700BEEF
W 03 3F00FFFF
W 04 030000FF
W 05 17005A5A
W 06 80000000
R 00 0FAAA5C3
R 03 3F00FFFF
R 05 17005A5A
R 06 80000000
S 83
C 000F 005A
W 00 4000000A
W 01 11000006
W 02 40000000
W 03 0B00C0DE
W 04 C0000000
R 00 4000000A
R 04 C0000000
S 35
C 00DE 0002
X 14
C 0000 0000
S 35
C 00DE 0002

// File: tag_trace_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_trace_mem
  (input  logic                     clk_i
  ,input  logic                     rst_i

  ,input  logic                     wb_cyc_i
  ,input  logic                     wb_stb_i
  ,input  logic                     wb_we_i
  ,input  logic [`TAG_TRACE_AW-1:0] wb_adr_i
  ,input  logic [31:0]              wb_dat_i
  ,output logic [31:0]              wb_dat_o
  ,output logic                     wb_ack_o

  ,trace_rd_if.mem                  rd
  );

  localparam int depth_lp = 1 << `TAG_TRACE_AW;

  logic [31:0] mem_r [0:depth_lp-1];

  // New Wishbone cycle, ack not yet given
  logic wb_hit;
  assign wb_hit = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  ////////////////////
  // Handshake state

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wb_ack_o    <= 1'b0;
      rd.rd_valid <= 1'b0;
    end
    else
    begin
      wb_ack_o    <= wb_hit;
      rd.rd_valid <= rd.rd_req;
    end
  end

  ////////////////////
  // Storage and read data

  always_ff @(posedge clk_i)
  begin
    if (wb_hit & wb_we_i)
      mem_r[wb_adr_i] <= wb_dat_i;

    if (wb_hit & ~wb_we_i)
      wb_dat_o <= mem_r[wb_adr_i];

    // Replay port, emptied once the entry is taken
    if (rd.rd_req)
      rd.rd_data <= mem_r[rd.rd_addr];
    else if (rd.rd_data_valid)
      rd.rd_data <= '0;
  end

endmodule

`default_nettype wire

// File: tag_trace_replay.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_trace_replay
  (input  logic       clk_i
  ,input  logic       rst_i
  ,input  logic       start_i

  ,trace_rd_if.replay rd

  ,output logic       tag_data_o
  ,output logic       busy_o
  ,output logic       done_o
  );

  import tag_pkg::*;

  // Start bit, node, len and payload
  localparam int pkt_w_lp = 1 + `TAG_NODE_W + `TAG_LEN_W + `TAG_PAYLOAD_W;

  replay_state_e            state_r;
  logic [`TAG_TRACE_AW-1:0] addr_r;
  logic                     req_sent_r;
  tag_entry_t               entry_r;
  logic [pkt_w_lp-1:0]      shift_r;
  tag_payload_t             cnt_r;
  logic                     last_addr;
  logic                     step;

  ////////////////////
  // Trace read path

  assign rd.rd_req        = (state_r == REPLAY_FETCH) & ~req_sent_r;
  assign rd.rd_addr       = addr_r;
  assign rd.rd_data_valid = (state_r == REPLAY_FETCH) & req_sent_r & rd.rd_valid;

  assign last_addr = &addr_r;

  // Entry finished, move on to the next address
  assign step = (((state_r == REPLAY_SHIFT) | (state_r == REPLAY_WAIT)) & (cnt_r == '0))
              | ((state_r == REPLAY_DECODE) & (entry_r.op == TAG_OP_WAIT)
                 & (entry_r.payload == '0));

  assign busy_o     = (state_r == REPLAY_FETCH) | (state_r == REPLAY_DECODE)
                    | (state_r == REPLAY_SHIFT) | (state_r == REPLAY_WAIT);
  assign done_o     = (state_r == REPLAY_DONE);
  assign tag_data_o = (state_r == REPLAY_SHIFT) & shift_r[0];

  ////////////////////
  // Control FSM

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r    <= REPLAY_IDLE;
      addr_r     <= '0;
      req_sent_r <= 1'b0;
      cnt_r      <= '0;
    end
    else
    begin
      case (state_r)
        REPLAY_IDLE, REPLAY_DONE:
          if (start_i)
          begin
            state_r    <= REPLAY_FETCH;
            addr_r     <= '0;
            req_sent_r <= 1'b0;
          end
        REPLAY_FETCH:
          if (!req_sent_r)
            req_sent_r <= 1'b1;
          else if (rd.rd_valid)
          begin
            req_sent_r <= 1'b0;
            state_r    <= REPLAY_DECODE;
          end
        REPLAY_DECODE:
          case (entry_r.op)
            TAG_OP_SEND:
            begin
              state_r <= REPLAY_SHIFT;
              // 7 header bits plus len+1 payload bits
              cnt_r   <= tag_payload_t'(entry_r.len) + tag_payload_t'(7);
            end
            TAG_OP_WAIT:
              if (entry_r.payload != '0)
              begin
                state_r <= REPLAY_WAIT;
                cnt_r   <= entry_r.payload - 1'b1;
              end
            default:
              state_r <= REPLAY_DONE;
          endcase
        REPLAY_SHIFT, REPLAY_WAIT:
          if (cnt_r != '0)
            cnt_r <= cnt_r - 1'b1;
        default:
          state_r <= REPLAY_IDLE;
      endcase

      if (step)
      begin
        if (last_addr)
          state_r <= REPLAY_DONE;
        else
        begin
          addr_r  <= addr_r + 1'b1;
          state_r <= REPLAY_FETCH;
        end
      end
    end
  end

  ////////////////////
  // Entry and serializer

  always_ff @(posedge clk_i)
  begin
    if (rd.rd_data_valid)
      entry_r <= tag_entry_t'(rd.rd_data);

    // LSB goes out first
    if (state_r == REPLAY_DECODE)
      shift_r <= {entry_r.payload, entry_r.len, entry_r.node, 1'b1};
    else if (state_r == REPLAY_SHIFT)
      shift_r <= shift_r >> 1;
  end

endmodule

`default_nettype wire

// File: tb_tag_boot.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tb_tag_boot;

  import tag_pkg::*;

  localparam int ack_timeout_lp  = 20;
  localparam int done_timeout_lp = 2000;
  localparam int depth_lp        = 1 << `TAG_TRACE_AW;

  logic                     clk_i;
  logic                     rst_i;
  logic                     start_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  logic                     wb_we_i;
  logic [`TAG_TRACE_AW-1:0] wb_adr_i;
  logic [31:0]              wb_dat_i;
  logic [31:0]              wb_dat_o;
  logic                     wb_ack_o;
  logic                     busy_o;
  logic                     done_o;
  logic                     tag_data_o;
  tag_payload_t             cfg0_o;
  tag_payload_t             cfg1_o;

  // Entries written so far, used to predict the serial line
  tag_entry_t               trace_model [0:depth_lp-1];
  logic                     line_exp_q [$];

  tag_boot_top i_tag_boot_top
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.start_i    (start_i)
    ,.wb_cyc_i   (wb_cyc_i)
    ,.wb_stb_i   (wb_stb_i)
    ,.wb_we_i    (wb_we_i)
    ,.wb_adr_i   (wb_adr_i)
    ,.wb_dat_i   (wb_dat_i)
    ,.wb_dat_o   (wb_dat_o)
    ,.wb_ack_o   (wb_ack_o)
    ,.busy_o     (busy_o)
    ,.done_o     (done_o)
    ,.tag_data_o (tag_data_o)
    ,.cfg0_o     (cfg0_o)
    ,.cfg1_o     (cfg1_o)
    );

  always #4 clk_i = ~clk_i;

  ////////////////////
  // Checks

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_entry(input string name, input tag_entry_t exp, input tag_entry_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_cfg(input string name, input tag_payload_t exp, input tag_payload_t act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
      stop_on_error();
    end
  endtask

  ////////////////////
  // Serial line model

  // One bit per cycle after start, from the packet format
  task automatic build_line_stream();
    tag_entry_t e;
    int         addr;
    int         i;
    logic       last;
    line_exp_q.delete();
    addr = 0;
    last = 1'b0;
    while (!last)
    begin
      e = trace_model[addr];
      // Fetch and decode keep the line low
      repeat (3) line_exp_q.push_back(1'b0);
      if (e.op == TAG_OP_SEND)
      begin
        line_exp_q.push_back(1'b1);
        for (i = 0; i < `TAG_NODE_W; i++)
          line_exp_q.push_back(e.node[i]);
        for (i = 0; i < `TAG_LEN_W; i++)
          line_exp_q.push_back(e.len[i]);
        for (i = 0; i <= int'(e.len); i++)
          line_exp_q.push_back(e.payload[i]);
      end
      else if (e.op == TAG_OP_WAIT)
        repeat (int'(e.payload)) line_exp_q.push_back(1'b0);
      else
        last = 1'b1;
      if (addr == depth_lp - 1)
        last = 1'b1;
      addr++;
    end
  endtask

  ////////////////////
  // Bus and control

  // One Wishbone classic access, data sampled while ack is high
  task automatic wb_access(input logic we, input logic [`TAG_TRACE_AW-1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    @(negedge clk_i);
    while (!wb_ack_o)
    begin
      if (waited == ack_timeout_lp)
      begin
        $display("Timeout waiting for the Wishbone ack at address %h", adr);
        stop_on_error();
      end
      waited++;
      @(negedge clk_i);
    end
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // Cycles are counted from the edge that samples start
  task automatic run_trace(input int min_cycles);
    int cycles;
    cycles = 0;
    build_line_stream();
    pulse_start();
    @(negedge clk_i);
    check_flag("busy_o", 1'b1, busy_o);
    check_flag("done_o", 1'b0, done_o);
    while (!done_o)
    begin
      if (cycles < line_exp_q.size())
        check_flag($sformatf("tag_data_o[%0d]", cycles), line_exp_q[cycles], tag_data_o);
      cycles++;
      if (cycles > done_timeout_lp)
      begin
        $display("Timeout waiting for done_o after start");
        stop_on_error();
      end
      @(negedge clk_i);
    end
    check_flag("busy_o", 1'b0, busy_o);
    if (cycles < min_cycles)
    begin
      $display("done_o rose after %0d cycles, earlier than the minimum of %0d", cycles,
               min_cycles);
      stop_on_error();
    end
  endtask

  // Optional partial run, then reset for 3 cycles
  task automatic apply_reset(input int run_cycles);
    if (run_cycles != 0)
    begin
      pulse_start();
      repeat (run_cycles) @(posedge clk_i);
    end
    else
      @(posedge clk_i);
    rst_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("done_o", 1'b0, done_o);
  endtask

  ////////////////////
  // Stimulus file

  initial
  begin
    string       line;
    int          fd;
    int          n;
    byte         cmd;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic [31:0] rdat;

    clk_i    = 1'b0;
    rst_i    = 1'b1;
    start_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    fd = $fopen("tag_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open tag_stim.txt for reading");
      stop_on_error();
    end

    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if ((n == 0) || (line.len() < 2))
        continue;
      cmd  = line.getc(0);
      arg0 = '0;
      arg1 = '0;
      n    = $sscanf(line.substr(1, line.len() - 1), "%h %h", arg0, arg1);
      case (cmd)
        "#":
          ;
        "W":
        begin
          wb_access(1'b1, arg0[`TAG_TRACE_AW-1:0], arg1, rdat);
          trace_model[arg0[`TAG_TRACE_AW-1:0]] = arg1;
        end
        "R":
        begin
          wb_access(1'b0, arg0[`TAG_TRACE_AW-1:0], '0, rdat);
          check_entry($sformatf("wb_dat_o[%h]", arg0[`TAG_TRACE_AW-1:0]), arg1, rdat);
        end
        "S":
          run_trace(int'(arg0));
        "C":
        begin
          check_cfg("cfg0_o", arg0[`TAG_PAYLOAD_W-1:0], cfg0_o);
          check_cfg("cfg1_o", arg1[`TAG_PAYLOAD_W-1:0], cfg1_o);
        end
        "X":
          apply_reset(int'(arg0));
        default:
        begin
          $display("Unknown command in tag_stim.txt: %s", line);
          stop_on_error();
        end
      endcase
    end
    $fclose(fd);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: trace_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

interface trace_rd_if;

  // Request side, from the replay engine
  logic                     rd_req;
  logic [`TAG_TRACE_AW-1:0] rd_addr;
  logic                     rd_data_valid;

  // Response side, one cycle after rd_req
  logic [31:0]              rd_data;
  logic                     rd_valid;

  modport replay (output rd_req, rd_addr, rd_data_valid, input rd_data, rd_valid);
  modport mem (input rd_req, rd_addr, rd_data_valid, output rd_data, rd_valid);

endinterface

`default_nettype wire
